/* files.f */
+incdir+verilog
verilog/arcade_pkg.sv
verilog/key_decoder.sv
verilog/input_debounce.sv
verilog/control_mapper.sv
verilog/sigma_delta_dac.sv
verilog/arcade_io_top.sv
tests/tb_arcade_io.sv

/* Makefile */
# Verilator flow for the arcade control and audio front end
# All variables below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_arcade_io
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Verification passed

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "TEST PASSED"; \
	else \
		echo "TEST FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/tb_arcade_io.sv */
// ----------------------------------------------------------------------
// Testbench for the arcade control and audio front end
// Reset, keyboard, joystick debounce, merge and rotation, audio DAC
// ----------------------------------------------------------------------

`include "arcade_defs.svh"

module tb_arcade_io
	import arcade_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int HALF         = 50;
	localparam int DB           = `ARC_DEBOUNCE_CYCLES;
	localparam int W            = `ARC_DAC_BITS;
	localparam int SETTLE_LIMIT = 4 * DB + 16;

	logic         clk_sys;
	logic         rst;
	key_event_t   key_evt;
	joy_t         joy_raw [2];
	logic         rotate_controls;
	logic         reset_req;
	logic [W-1:0] audio;
	game_ctrl_t   ctrl;
	logic         game_reset;
	logic         audio_l;
	logic         audio_r;
	joy_t         joy_clean [2]; // Debouncer outputs inside the DUT

	integer       seed;
	logic [31:0]  rnd;
	kbd_buttons_t kbd_exp;
	joy_t         joy_exp [2];   // Settled joystick levels
	logic         rot_exp;
	logic [7:0]   key_codes [9] = '{`ARC_KEY_RIGHT, `ARC_KEY_LEFT, `ARC_KEY_DOWN,
		`ARC_KEY_UP, `ARC_KEY_FIRE1, `ARC_KEY_FIRE2, `ARC_KEY_START1,
		`ARC_KEY_START2, `ARC_KEY_COIN}; // In kbd_buttons_t bit order

	// Debounce model state per joystick
	joy_t s0 [2];
	joy_t s1 [2];
	joy_t prev_s1 [2];
	joy_t past_s1 [2];
	joy_t past_clean [2];
	int   run [2];
	int   past_run [2];
	logic rst_d1;
	logic rst_d2;
	logic req_d1;

	arcade_io_top dut0 (
		.clk_sys         (clk_sys),
		.rst             (rst),
		.key_evt         (key_evt),
		.joy0_raw        (joy_raw[0]),
		.joy1_raw        (joy_raw[1]),
		.rotate_controls (rotate_controls),
		.reset_req       (reset_req),
		.audio           (audio),
		.ctrl            (ctrl),
		.game_reset      (game_reset),
		.audio_l         (audio_l),
		.audio_r         (audio_r)
	);

	assign joy_clean[0] = dut0.joy0_clean;
	assign joy_clean[1] = dut0.joy1_clean;

	initial begin
		clk_sys = 1'b0;
		forever #HALF clk_sys = ~clk_sys;
	end

	task automatic error_stop(input string msg);
		$display("Fail at %0d ns: %s", $time, msg);
		$display("Verification failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic timeout_stop(input string what);
		$display("Timeout: %s did not happen within the allowed cycles", what);
		$display("Verification failed");
		$fatal(1, "run stopped on timeout");
	endtask

	function automatic kbd_buttons_t apply_key(input kbd_buttons_t k, input logic pressed,
		input logic [7:0] code);
		kbd_buttons_t n;
		n = k;
		case (code)
			`ARC_KEY_UP:     n.up     = pressed;
			`ARC_KEY_DOWN:   n.down   = pressed;
			`ARC_KEY_LEFT:   n.left   = pressed;
			`ARC_KEY_RIGHT:  n.right  = pressed;
			`ARC_KEY_COIN:   n.coin   = pressed;
			`ARC_KEY_START1: n.start1 = pressed;
			`ARC_KEY_START2: n.start2 = pressed;
			`ARC_KEY_FIRE1:  n.fire1  = pressed;
			`ARC_KEY_FIRE2:  n.fire2  = pressed;
			default:         n        = k; // Unmapped code
		endcase
		return n;
	endfunction

	function automatic logic is_mapped(input logic [7:0] code);
		logic hit;
		hit = 1'b0;
		for (int j = 0; j < 9; j++) begin
			if (key_codes[j] == code) hit = 1'b1;
		end
		return hit;
	endfunction

	// OR over all sources and rotation picks the axis
	function automatic game_ctrl_t expect_ctrl();
		game_ctrl_t c;
		c = '0;
		if (rot_exp) begin
			c.left  = kbd_exp.left | joy_exp[0].left | joy_exp[1].left;
			c.right = kbd_exp.right | joy_exp[0].right | joy_exp[1].right;
		end else begin
			c.left  = kbd_exp.down | joy_exp[0].down | joy_exp[1].down;
			c.right = kbd_exp.up | joy_exp[0].up | joy_exp[1].up;
		end
		c.fire    = kbd_exp.fire1 | joy_exp[0].fire | joy_exp[1].fire;
		c.barrier = kbd_exp.fire2 | joy_exp[0].bomb | joy_exp[1].bomb;
		c.coin    = kbd_exp.coin;
		c.start1  = kbd_exp.start1;
		c.start2  = kbd_exp.start2;
		return c;
	endfunction

	task automatic check_ctrl(input string what);
		game_ctrl_t exp;
		exp = expect_ctrl();
		assert (ctrl == exp)
			else error_stop($sformatf("%s, ctrl %b expected %b", what, ctrl, exp));
	endtask

	task automatic send_key(input logic pressed, input logic [7:0] code);
		@(posedge clk_sys);
		key_evt <= {1'b1, pressed, code};
		@(posedge clk_sys);
		key_evt <= '0;
		kbd_exp = apply_key(kbd_exp, pressed, code);
		repeat (2) @(posedge clk_sys); // Decoder, then mapper register
		check_ctrl($sformatf("key %h pressed=%b", code, pressed));
	endtask

	task automatic set_keys(input kbd_buttons_t want);
		for (int j = 0; j < 9; j++) begin
			if (want[j] != kbd_exp[j]) send_key(want[j], key_codes[j]);
		end
	endtask

	task automatic settle_joys();
		int t;
		t = 0;
		while ((joy_clean[0] != joy_exp[0] || joy_clean[1] != joy_exp[1]) &&
			t < SETTLE_LIMIT) begin
			@(posedge clk_sys);
			t++;
		end
		if (joy_clean[0] != joy_exp[0] || joy_clean[1] != joy_exp[1]) begin
			timeout_stop("joystick debounce");
		end
		repeat (2) @(posedge clk_sys); // Covers a rotation change too
		check_ctrl("settled joysticks");
	endtask

	task automatic wait_ctrl(input string what);
		int t;
		t = 0;
		while (ctrl != expect_ctrl() && t < SETTLE_LIMIT) begin
			@(posedge clk_sys);
			t++;
		end
		if (ctrl != expect_ctrl()) timeout_stop(what);
	endtask

	task automatic glitch_joy(input int idx, input joy_t pattern, input int len);
		for (int n = 0; n < len; n++) begin
			@(posedge clk_sys);
			joy_raw[idx] <= pattern;
			check_ctrl("during joystick glitch");
		end
		@(posedge clk_sys);
		joy_raw[idx] <= joy_exp[idx];
		repeat (DB + 4) begin
			@(posedge clk_sys);
			check_ctrl("after joystick glitch");
		end
	endtask

	// Ones over one full accumulator period equal the sample
	task automatic audio_run(input logic [W-1:0] value);
		int ones;
		ones = 0;
		@(posedge clk_sys);
		rst   <= 1'b1;
		audio <= value;
		repeat (16) @(posedge clk_sys);
		rst     <= 1'b0;
		kbd_exp = '0;
		@(posedge clk_sys); // Carry of the first add shows next edge
		repeat (1 << W) begin
			@(posedge clk_sys);
			if (audio_l) ones++;
		end
		assert (ones == int'(value))
			else error_stop($sformatf("audio %h gave %0d ones", value, ones));
	endtask

	// ----------------------------------------------------------------------
	// Reset, game reset and debounce timing checks
	// ----------------------------------------------------------------------
	always @(posedge clk_sys) begin
		rst_d1 <= rst;
		rst_d2 <= rst_d1;
		req_d1 <= reset_req;
		if ($time > 2 * HALF) begin // First edge has no history
			assert (game_reset == (rst_d1 | req_d1))
				else error_stop($sformatf("game_reset %b", game_reset));
			if (rst_d1 || rst_d2) begin
				assert (ctrl == '0) else error_stop("ctrl not zero around reset");
			end
		end
		for (int i = 0; i < 2; i++) begin
			if (rst) begin
				s0[i]      <= '0;
				s1[i]      <= '0;
				prev_s1[i] <= '0;
				run[i]     <= 0;
			end else begin
				s0[i]      <= joy_raw[i];
				s1[i]      <= s0[i];
				prev_s1[i] <= s1[i];
				run[i]     <= (s1[i] == prev_s1[i]) ? run[i] + 1 : 1;
			end
			past_s1[i]    <= s1[i];
			past_run[i]   <= run[i];
			past_clean[i] <= joy_clean[i];
			if ($time > 2 * HALF && !rst_d1 && joy_clean[i] != past_clean[i]) begin
				assert (past_run[i] >= DB && joy_clean[i] == past_s1[i])
					else error_stop($sformatf("joystick %0d changed after %0d stable samples",
						i, past_run[i]));
			end
		end
	end

	audio_mirror: assert property (@(posedge clk_sys) disable iff (rst) audio_r == audio_l)
		else error_stop("audio_r does not follow audio_l");

	initial begin
		seed            = 32'h76f5cf10;
		rst             = 1'b1;
		key_evt         = '0;
		joy_raw[0]      = '0;
		joy_raw[1]      = '0;
		rotate_controls = 1'b0;
		reset_req       = 1'b0;
		audio           = '0;
		kbd_exp         = '0;
		joy_exp[0]      = '0;
		joy_exp[1]      = '0;
		rot_exp         = 1'b0;
		repeat (16) @(posedge clk_sys);
		rst <= 1'b0;
		repeat (3) @(posedge clk_sys);

		// Game reset requests
		repeat (4) begin
			@(posedge clk_sys);
			reset_req <= 1'b1;
			@(posedge clk_sys);
			reset_req <= 1'b0;
			rnd = $random(seed);
			repeat (1 + int'(rnd[2:0])) @(posedge clk_sys);
		end

		// Every key in both rotation settings
		for (int r = 0; r < 2; r++) begin
			@(posedge clk_sys);
			rot_exp = r[0];
			rotate_controls <= r[0];
			repeat (2) @(posedge clk_sys);
			for (int j = 0; j < 9; j++) begin
				send_key(1'b1, key_codes[j]);
				send_key(1'b0, key_codes[j]);
			end
		end
		set_keys(9'h0A5); // Held keys must survive unmapped codes
		repeat (16) begin
			rnd = $random(seed);
			if (!is_mapped(rnd[7:0])) send_key(rnd[8], rnd[7:0]);
		end
		set_keys('0);

		// ----------------------------------------------------------------------
		// Joystick glitches and stable levels
		// ----------------------------------------------------------------------
		repeat (24) begin
			rnd = $random(seed);
			glitch_joy(int'(rnd[31]), rnd[7:0], 1 + int'(rnd[15:8]) % (DB - 1));
		end
		for (int j = 0; j < 2; j++) begin
			rnd = $random(seed);
			@(posedge clk_sys);
			joy_exp[j] = rnd[7:0] | 8'h10; // Fire always set
			joy_raw[j] <= joy_exp[j];
			wait_ctrl("stable joystick level on ctrl");
			settle_joys();
			glitch_joy(j, '0, DB - 1);
		end
		@(posedge clk_sys);
		joy_exp[0] = '0;
		joy_exp[1] = '0;
		joy_raw[0] <= '0;
		joy_raw[1] <= '0;
		settle_joys();

		// Random merges in both rotation settings
		repeat (16) begin
			rnd = $random(seed);
			@(posedge clk_sys);
			rot_exp    = rnd[16];
			joy_exp[0] = rnd[7:0];
			joy_exp[1] = rnd[15:8];
			rotate_controls <= rot_exp;
			joy_raw[0]      <= joy_exp[0];
			joy_raw[1]      <= joy_exp[1];
			settle_joys();
			set_keys(rnd[25:17]);
			check_ctrl("merged controls");
		end

		// Audio DAC
		rnd = $random(seed);
		audio_run('0);
		audio_run(W'(1));
		audio_run({1'b1, {(W - 1){1'b0}}});
		audio_run('1);
		audio_run(W'(1365));
		audio_run(rnd[W-1:0]);

		$display("Verification passed");
		$finish;
	end

endmodule

/* verilog/arcade_io_top.sv */
// ---------------------------------------------------------------------
// Arcade control and audio front end, top level
// Key decoder, joystick debouncers, control mapper and audio DAC
// ---------------------------------------------------------------------

`include "arcade_defs.svh"

module arcade_io_top
	import arcade_pkg::*;
(
	input  logic                     clk_sys,
	input  logic                     rst,
	input  key_event_t               key_evt,
	input  joy_t                     joy0_raw,   // Asynchronous
	input  joy_t                     joy1_raw,   // Asynchronous
	input  logic                     rotate_controls,
	input  logic                     reset_req,
	input  logic [`ARC_DAC_BITS-1:0] audio,
	output game_ctrl_t               ctrl,
	output logic                     game_reset,
	output logic                     audio_l,
	output logic                     audio_r
);

	kbd_buttons_t kbd_buttons;
	joy_t         joy0_clean;
	joy_t         joy1_clean;

	// ---------------------------------------------------------------------
	// Input paths
	// ---------------------------------------------------------------------
	key_decoder key_dec (
		.clk_sys (clk_sys),
		.rst     (rst),
		.key_evt (key_evt),
		.buttons (kbd_buttons)
	);

	input_debounce #(.payload_t(joy_t)) joy0_deb (
		.clk_sys (clk_sys),
		.rst     (rst),
		.raw     (joy0_raw),
		.clean   (joy0_clean)
	);

	input_debounce #(.payload_t(joy_t)) joy1_deb (
		.clk_sys (clk_sys),
		.rst     (rst),
		.raw     (joy1_raw),
		.clean   (joy1_clean)
	);

	control_mapper ctrl_map (
		.clk_sys         (clk_sys),
		.rst             (rst),
		.kbd             (kbd_buttons),
		.joy0            (joy0_clean),
		.joy1            (joy1_clean),
		.rotate_controls (rotate_controls),
		.reset_req       (reset_req),
		.ctrl            (ctrl),
		.game_reset      (game_reset)
	);

	// ---------------------------------------------------------------------
	// Mono audio to both channels
	// ---------------------------------------------------------------------
	sigma_delta_dac audio_dac (
		.clk_sys (clk_sys),
		.rst     (rst),
		.sample  (audio),
		.dac_out (audio_l)
	);

	assign audio_r = audio_l;

endmodule

/* verilog/sigma_delta_dac.sv */
// ---------------------------------------------------------------------
// First-order sigma-delta DAC
// One-bit density output for an unsigned audio sample
// ---------------------------------------------------------------------

`include "arcade_defs.svh"

module sigma_delta_dac (
	input  logic                     clk_sys,
	input  logic                     rst,
	input  logic [`ARC_DAC_BITS-1:0] sample,
	output logic                     dac_out
);

	localparam int unsigned W = `ARC_DAC_BITS;

	logic [W-1:0] acc_q;
	logic [W:0]   acc_sum; // Extra bit holds the carry

	assign acc_sum = {1'b0, acc_q} + {1'b0, sample};

	// Carry density over 2^W cycles equals sample / 2^W
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			acc_q   <= '0;
			dac_out <= 1'b0;
		end else begin
			acc_q   <= acc_sum[W-1:0];
			dac_out <= acc_sum[W];
		end
	end

endmodule

/* verilog/control_mapper.sv */
// ---------------------------------------------------------------------
// Control mapper
// Merges keyboard and joysticks, applies rotation, registers outputs
// ---------------------------------------------------------------------

module control_mapper
	import arcade_pkg::*;
(
	input  logic         clk_sys,
	input  logic         rst,
	input  kbd_buttons_t kbd,
	input  joy_t         joy0,
	input  joy_t         joy1,
	input  logic         rotate_controls,
	input  logic         reset_req,
	output game_ctrl_t   ctrl,
	output logic         game_reset
);

	game_ctrl_t ctrl_d;
	game_ctrl_t ctrl_q;
	logic       game_reset_q;
	logic       any_up;
	logic       any_down;
	logic       any_left;
	logic       any_right;

	// Direction sources over all three devices
	assign any_up    = kbd.up    | joy0.up    | joy1.up;
	assign any_down  = kbd.down  | joy0.down  | joy1.down;
	assign any_left  = kbd.left  | joy0.left  | joy1.left;
	assign any_right = kbd.right | joy0.right | joy1.right;

	always_comb begin
		ctrl_d = '0;
		// Unrotated cabinet steers with the vertical stick axis
		if (rotate_controls) begin
			ctrl_d.left  = any_left;
			ctrl_d.right = any_right;
		end else begin
			ctrl_d.left  = any_down;
			ctrl_d.right = any_up;
		end
		ctrl_d.fire    = kbd.fire1 | joy0.fire | joy1.fire;
		ctrl_d.barrier = kbd.fire2 | joy0.bomb | joy1.bomb;
		ctrl_d.coin    = kbd.coin;   // Keyboard only
		ctrl_d.start1  = kbd.start1;
		ctrl_d.start2  = kbd.start2;
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ctrl_q       <= '0;
			game_reset_q <= 1'b1; // Game held in reset with the front end
		end else begin
			ctrl_q       <= ctrl_d;
			game_reset_q <= reset_req;
		end
	end

	assign ctrl       = ctrl_q;
	assign game_reset = game_reset_q;

endmodule

/* verilog/input_debounce.sv */
// ---------------------------------------------------------------------
// Two-flop synchronizer and debouncer for a packed payload
// ---------------------------------------------------------------------

`include "arcade_defs.svh"

module input_debounce #(
	parameter type payload_t = logic
) (
	input  logic     clk_sys,
	input  logic     rst,
	input  payload_t raw,
	output payload_t clean
);

	localparam int unsigned DB_CYCLES = `ARC_DEBOUNCE_CYCLES;
	localparam int unsigned CNT_W     = $clog2(DB_CYCLES + 1);

	payload_t       sync_q0;
	payload_t       sync_q1;
	payload_t       samp_q;  // Previous synchronized sample
	payload_t       clean_q;
	logic [CNT_W-1:0] run_cnt;

	// ---------------------------------------------------------------------
	// Synchronizer
	// ---------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			sync_q0 <= '0;
			sync_q1 <= '0;
			samp_q  <= '0;
		end else begin
			sync_q0 <= raw;
			sync_q1 <= sync_q0;
			samp_q  <= sync_q1;
		end
	end

	// ---------------------------------------------------------------------
	// Stability counter
	// ---------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			run_cnt <= '0;
			clean_q <= '0;
		end else if (sync_q1 != samp_q || sync_q1 == clean_q) begin
			run_cnt <= '0; // Input moved, or nothing to update
		end else if (run_cnt == CNT_W'(DB_CYCLES - 1)) begin
			run_cnt <= '0;
			clean_q <= samp_q;
		end else begin
			run_cnt <= run_cnt + 1'b1;
		end
	end

	assign clean = clean_q;

endmodule

/* verilog/key_decoder.sv */
// ---------------------------------------------------------------------
// Keyboard scan-code decoder
// Holds the pressed state of each mapped key between events
// ---------------------------------------------------------------------

`include "arcade_defs.svh"

module key_decoder
	import arcade_pkg::*;
(
	input  logic         clk_sys,
	input  logic         rst,
	input  key_event_t   key_evt,
	output kbd_buttons_t buttons
);

	kbd_buttons_t btn_q;

	// Only a strobe touches the state and unknown codes fall through
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			btn_q <= '0;
		end else if (key_evt.strobe) begin
			case (key_evt.code)
				`ARC_KEY_UP: begin
					btn_q.up <= key_evt.pressed;
				end
				`ARC_KEY_DOWN: begin
					btn_q.down <= key_evt.pressed;
				end
				`ARC_KEY_LEFT: begin
					btn_q.left <= key_evt.pressed;
				end
				`ARC_KEY_RIGHT: begin
					btn_q.right <= key_evt.pressed;
				end
				`ARC_KEY_COIN: begin
					btn_q.coin <= key_evt.pressed;
				end
				`ARC_KEY_START1: begin
					btn_q.start1 <= key_evt.pressed; // One player
				end
				`ARC_KEY_START2: begin
					btn_q.start2 <= key_evt.pressed; // Two players
				end
				`ARC_KEY_FIRE1: begin
					btn_q.fire1 <= key_evt.pressed;
				end
				`ARC_KEY_FIRE2: begin
					btn_q.fire2 <= key_evt.pressed;
				end
				default: begin
					btn_q <= btn_q;
				end
			endcase
		end
	end

	assign buttons = btn_q;

endmodule

/* verilog/arcade_pkg.sv */
// ---------------------------------------------------------------------
// Packed types of the arcade control front end
// Key events, joystick ports, keyboard buttons and game controls
// ---------------------------------------------------------------------

package arcade_pkg;

	// One keyboard event from the host link
	typedef struct packed {
		logic       strobe;  // Valid for one cycle
		logic       pressed; // 1 on make, 0 on break
		logic [7:0] code;
	} key_event_t;

	// Raw or debounced joystick port, active high
	typedef struct packed {
		logic [1:0] spare;
		logic       bomb;
		logic       fire;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joy_t;

	// Held state of the mapped keys
	typedef struct packed {
		logic coin;
		logic start2;
		logic start1;
		logic fire2;
		logic fire1;
		logic up;
		logic down;
		logic left;
		logic right;
	} kbd_buttons_t;

	// Controls as seen by the game core
	typedef struct packed {
		logic coin;
		logic start2;
		logic start1;
		logic barrier;
		logic fire;
		logic left;
		logic right;
	} game_ctrl_t;

endpackage

/* verilog/arcade_defs.svh */
// ---------------------------------------------------------------------
// Shared constants of the arcade control and audio front end
// Debounce length, DAC width and keyboard scan codes
// ---------------------------------------------------------------------

`ifndef ARCADE_DEFS_SVH
`define ARCADE_DEFS_SVH

// Stable samples needed before a debounced output moves
`define ARC_DEBOUNCE_CYCLES 8

// Width of the audio sample and of the DAC accumulator core
`define ARC_DAC_BITS 12

// ---------------------------------------------------------------------
// PS/2 set 2 scan codes of the mapped keys
// ---------------------------------------------------------------------
`define ARC_KEY_UP     8'h75 // Keypad 8
`define ARC_KEY_DOWN   8'h72 // Keypad 2
`define ARC_KEY_LEFT   8'h6B // Keypad 4
`define ARC_KEY_RIGHT  8'h74 // Keypad 6
`define ARC_KEY_COIN   8'h76 // Esc
`define ARC_KEY_START1 8'h05 // F1
`define ARC_KEY_START2 8'h06 // F2
`define ARC_KEY_FIRE1  8'h29 // Space
`define ARC_KEY_FIRE2  8'h11 // Alt

`endif
